// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	// mult/div opcodes as the core decoder encodes them
	typedef enum logic [1:0] {
		mult  = 2'b00,
		multu = 2'b01,
		div   = 2'b10,
		divu  = 2'b11
	} md_op_e;

	typedef enum logic {
		md_free = 1'b0, // ready for a new op
		md_busy = 1'b1  // divide running
	} md_state_e;

	// load/store access width
	typedef enum logic [1:0] {
		sz_byte = 2'b00,
		sz_half = 2'b01,
		sz_word = 2'b10
	} mem_size_e;

	typedef enum logic {
		lo = 1'b0,
		hi = 1'b1
	} hilo_sel_e;

	// mult/div request from the core
	typedef struct packed {
		md_op_e      op;
		logic [31:0] a; // rs
		logic [31:0] b; // rt
	} md_req_t;

	// mthi / mtlo
	typedef struct packed {
		logic        en;
		hilo_sel_e   sel;
		logic [31:0] data;
	} hilo_wr_t;

	typedef struct packed {
		logic        wr;    // store
		logic        rd;    // load
		mem_size_e   size;
		logic        sext;  // lb/lh vs lbu/lhu
		logic [31:0] addr;  // core virtual address
		logic [31:0] wdata;
	} mem_req_t;

	// always enabled data sram port
	typedef struct packed {
		logic [3:0]  wen;
		logic [31:0] addr;
		logic [31:0] wdata;
	} sram_req_t;

	localparam logic [31:0] dsram_base = 32'ha000_0000; // kseg1 data window
	localparam int div_steps = 32;                      // one quotient bit per step
	localparam int div_cnt_w = $clog2(div_steps);
	localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(div_steps - 1);

endpackage

// ==== logic/hilo_ctrl.sv ====
`timescale 1ns/100ps

// sequencing for the mult/div unit
// multiply takes one cycle while divide holds busy until the divider reports done
module hilo_ctrl (
	input  logic             aclk,
	input  logic             aresetn,
	input  cpu_pkg::md_op_e  req_op,
	input  logic             start,
	input  logic             flush,      // exception or eret in mem
	input  logic             div_done,
	output logic             busy,
	output logic             mul_load,
	output logic             div_go,
	output logic             div_signed,
	output logic             mul_signed,
	output logic             hilo_wr_ok
);

	cpu_pkg::md_state_e state;
	cpu_pkg::md_state_e state_nxt;
	logic               is_div;
	logic               accept;

	// op decode
	assign is_div     = (req_op == cpu_pkg::div) || (req_op == cpu_pkg::divu);
	assign div_signed = (req_op == cpu_pkg::div);
	assign mul_signed = (req_op == cpu_pkg::mult);

	// start only counts when idle and not flushed
	assign accept = start && !flush && (state == cpu_pkg::md_free);

	assign mul_load = accept && !is_div; // product lands next edge
	assign div_go   = accept && is_div;  // divider latches operands

	always_comb begin
		state_nxt = state;
		case (state)
			cpu_pkg::md_free: begin
				if (div_go) begin
					state_nxt = cpu_pkg::md_busy;
				end
			end
			cpu_pkg::md_busy: begin
				if (div_done) begin // result loads this edge
					state_nxt = cpu_pkg::md_free;
				end
			end
			default: state_nxt = cpu_pkg::md_free;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= cpu_pkg::md_free;
		end else begin
			state <= state_nxt;
		end
	end

	// busy follows the next state, so the core stalls in the start cycle already
	assign busy = (state_nxt == cpu_pkg::md_busy);

	// mthi/mtlo blocked while a divide owns hi/lo
	assign hilo_wr_ok = !busy;

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/100ps

// single cycle 32x32 -> 64 multiplier
// signed case works on sign-extended 64 bit operands
// so the low 64 bits of the product are exact for both signednesses
module mul_unit (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic        is_signed,
	output logic [63:0] product
);

	logic [63:0] a_x; // extended rs
	logic [63:0] b_x; // extended rt
	logic        a_fill;
	logic        b_fill;

	assign a_fill = is_signed & a[31]; // zero fill for multu
	assign b_fill = is_signed & b[31];

	assign a_x = {{32{a_fill}}, a};
	assign b_x = {{32{b_fill}}, b};

	assign product = a_x * b_x; // upper bits drop out

endmodule

// ==== logic/div_unit.sv ====
`timescale 1ns/100ps

// iterative restoring divider
// go latches operands, then div_steps shift-subtract cycles
// then one cycle to apply signs before done pulses with the result
module div_unit (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        go,
	input  logic        is_signed,
	input  logic [31:0] dividend,
	input  logic [31:0] divisor,
	output logic        done,
	output logic [31:0] quotient,
	output logic [31:0] remainder
);

	logic                          run;    // shift-subtract phase
	logic                          fin;    // sign fix-up cycle
	logic [cpu_pkg::div_cnt_w-1:0] cnt;    // step index
	logic [31:0]                   dq;     // dividend bits out, quotient bits in
	logic [31:0]                   dvs;    // divisor magnitude
	logic [31:0]                   part;   // partial remainder
	logic                          q_neg;
	logic                          r_neg;
	logic                          a_neg;
	logic                          b_neg;
	logic [32:0]                   part_sh;
	logic [32:0]                   diff;

	assign a_neg = is_signed & dividend[31];
	assign b_neg = is_signed & divisor[31];

	// bring in next dividend bit and trial subtract
	assign part_sh = {part, dq[31]};
	assign diff    = part_sh - {1'b0, dvs};

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			run  <= 1'b0;
			fin  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= fin;                                 // one-cycle pulse
			fin  <= run && (cnt == cpu_pkg::div_last);   // after the last step
			if (go) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == cpu_pkg::div_last) begin
					run <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (go) begin
			dq    <= a_neg ? -dividend : dividend; // 0x8000_0000 stays as magnitude
			dvs   <= b_neg ? -divisor : divisor;
			part  <= '0;
			q_neg <= a_neg ^ b_neg;
			r_neg <= a_neg; // remainder follows dividend
		end else if (run) begin
			// restore on borrow and keep the difference otherwise
			part <= diff[32] ? part_sh[31:0] : diff[31:0];
			dq   <= {dq[30:0], ~diff[32]};
		end
		if (fin) begin
			quotient  <= q_neg ? -dq : dq;
			remainder <= r_neg ? -part : part;
		end
	end

endmodule

// ==== logic/hilo_reg.sv ====
`timescale 1ns/100ps

// hi/lo pair and its read port
module hilo_reg (
	input  logic                aclk,
	input  logic                aresetn,
	input  logic                mul_load,
	input  logic [63:0]         product,
	input  logic                div_load,
	input  logic [31:0]         quotient,
	input  logic [31:0]         remainder,
	input  cpu_pkg::hilo_wr_t   wr,
	input  logic                wr_ok,
	input  cpu_pkg::hilo_sel_e  rd_sel,
	output logic [31:0]         rdata
);

	logic [31:0] hi_r;
	logic [31:0] lo_r;

	// mult wins over div result and direct write comes last
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			hi_r <= '0;
			lo_r <= '0;
		end else if (mul_load) begin
			hi_r <= product[63:32];
			lo_r <= product[31:0];
		end else if (div_load) begin
			hi_r <= remainder;
			lo_r <= quotient;
		end else if (wr.en && wr_ok) begin
			if (wr.sel == cpu_pkg::hi) begin // mthi
				hi_r <= wr.data;
			end else begin                   // mtlo
				lo_r <= wr.data;
			end
		end
	end

	// mfhi / mflo
	assign rdata = (rd_sel == cpu_pkg::hi) ? hi_r : lo_r;

endmodule

// ==== logic/dsram_bridge.sv ====
`timescale 1ns/100ps

// core to data sram adapter
// stores are formatted in the request cycle and loads extracted a cycle later
module dsram_bridge (
	input  logic                aclk,
	input  logic                aresetn,
	input  cpu_pkg::mem_req_t   req,
	output cpu_pkg::sram_req_t  sram,
	input  logic [31:0]         sram_rdata,
	output logic [31:0]         load_data
);

	cpu_pkg::mem_size_e ld_size; // load shape held for the data cycle
	logic               ld_sext;
	logic [1:0]         ld_off;
	logic [7:0]         ld_byte;
	logic [15:0]        ld_half;

	// lane enables and replicated store data
	always_comb begin
		sram.wen   = 4'b0000;
		sram.wdata = req.wdata;
		case (req.size)
			cpu_pkg::sz_byte: begin
				sram.wdata = {4{req.wdata[7:0]}};
				if (req.wr) begin
					sram.wen = 4'b0001 << req.addr[1:0]; // one lane
				end
			end
			cpu_pkg::sz_half: begin
				sram.wdata = {2{req.wdata[15:0]}};
				if (req.wr) begin
					sram.wen = req.addr[1] ? 4'b1100 : 4'b0011;
				end
			end
			default: begin
				if (req.wr) begin
					sram.wen = 4'b1111; // sw
				end
			end
		endcase
	end

	// word aligned address relative to the sram window
	assign sram.addr = {req.addr[31:2], 2'b00} - cpu_pkg::dsram_base;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			ld_size <= cpu_pkg::sz_word;
			ld_sext <= 1'b0;
			ld_off  <= 2'b00;
		end else if (req.rd) begin
			ld_size <= req.size;
			ld_sext <= req.sext;
			ld_off  <= req.addr[1:0];
		end
	end

	// pick the addressed field out of the returned word
	always_comb begin
		case (ld_off)
			2'b00:   ld_byte = sram_rdata[7:0];
			2'b01:   ld_byte = sram_rdata[15:8];
			2'b10:   ld_byte = sram_rdata[23:16];
			default: ld_byte = sram_rdata[31:24];
		endcase
		ld_half = ld_off[1] ? sram_rdata[31:16] : sram_rdata[15:0];
	end

	always_comb begin
		case (ld_size)
			cpu_pkg::sz_byte: load_data = {{24{ld_sext & ld_byte[7]}}, ld_byte};  // lb/lbu
			cpu_pkg::sz_half: load_data = {{16{ld_sext & ld_half[15]}}, ld_half}; // lh/lhu
			default:          load_data = sram_rdata;                             // lw
		endcase
	end

endmodule

// ==== logic/exu_top.sv ====
`timescale 1ns/100ps

// execute-side helpers with mult/div, hi/lo and the data sram bridge
module exu_top (
	input  logic                aclk,
	input  logic                aresetn,
	input  cpu_pkg::md_req_t    md_req,
	input  logic                start,
	input  logic                flush,
	input  cpu_pkg::hilo_wr_t   hilo_wr,
	input  cpu_pkg::hilo_sel_e  rd_sel,
	output logic                busy,
	output logic [31:0]         hilo_rdata,
	input  cpu_pkg::mem_req_t   mem_req,
	output cpu_pkg::sram_req_t  sram,
	input  logic [31:0]         sram_rdata,
	output logic [31:0]         load_data
);

	logic        mul_load;
	logic        div_go;
	logic        div_signed;
	logic        mul_signed;
	logic        hilo_wr_ok;
	logic        div_done;
	logic [63:0] product;
	logic [31:0] quotient;
	logic [31:0] remainder;

	hilo_ctrl u_ctrl (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.req_op     (md_req.op),
		.start      (start),
		.flush      (flush),
		.div_done   (div_done),
		.busy       (busy),
		.mul_load   (mul_load),
		.div_go     (div_go),
		.div_signed (div_signed),
		.mul_signed (mul_signed),
		.hilo_wr_ok (hilo_wr_ok)
	);

	mul_unit u_mul (
		.a         (md_req.a),
		.b         (md_req.b),
		.is_signed (mul_signed),
		.product   (product)
	);

	div_unit u_div (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.go        (div_go),
		.is_signed (div_signed),
		.dividend  (md_req.a),
		.divisor   (md_req.b),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	hilo_reg u_hilo (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.mul_load  (mul_load),
		.product   (product),
		.div_load  (div_done),
		.quotient  (quotient),
		.remainder (remainder),
		.wr        (hilo_wr),
		.wr_ok     (hilo_wr_ok),
		.rd_sel    (rd_sel),
		.rdata     (hilo_rdata)
	);

	dsram_bridge u_dsram (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.req        (mem_req),
		.sram       (sram),
		.sram_rdata (sram_rdata),
		.load_data  (load_data)
	);

endmodule

// ==== verif/exu_tb.sv ====
`timescale 1ns/100ps

module exu_tb;

	localparam int n_mul = 16;
	localparam int n_div = 12;
	localparam int n_ops = n_mul + n_div + 2 + 4 + 40; // + flushes, direct writes, mem ops

	logic                   aclk = 1'b0;
	logic                   aresetn;
	cpu_pkg::md_req_t       md_req;
	logic                   start;
	logic                   flush;
	cpu_pkg::hilo_wr_t      hilo_wr;
	cpu_pkg::hilo_sel_e     rd_sel;
	logic                   busy;
	logic [31:0]            hilo_rdata;
	cpu_pkg::mem_req_t      mem_req;
	cpu_pkg::sram_req_t     sram;
	logic [31:0]            sram_rdata;
	logic [31:0]            load_data;

	logic [31:0] mem [0:63];     // sram contents
	logic [31:0] ref_mem [0:63]; // expected sram contents
	logic [31:0] exp_hi = '0;
	logic [31:0] exp_lo = '0;
	logic [31:0] seed = 32'd12;
	int          checks = 0;
	int          errors = 0;

	exu_top DUT (.*);

	always #4 aclk = ~aclk; // 8 ns period

	// data sram model with one cycle read latency and byte lanes
	always @(posedge aclk) begin
		for (int i = 0; i < 4; i++) begin
			if (sram.wen[i]) begin
				mem[sram.addr[7:2]][8*i +: 8] <= sram.wdata[8*i +: 8];
			end
		end
		sram_rdata <= mem[sram.addr[7:2]];
	end

	// no lane may be written without a store
	no_stray_wen: assert property (@(posedge aclk) disable iff (!aresetn)
		!mem_req.wr |-> (sram.wen == 4'b0000))
	else begin
		errors++;
		$display("CHECK FAILED at %0t: sram wen %b without a store", $time, sram.wen);
	end

	function logic [31:0] next_rand(); // lcg with numerical recipes constants
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [63:0] mul_ref(input cpu_pkg::md_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		longint          sa;
		longint          sb;
		longint unsigned ua;
		longint unsigned ub;
		sa = int'(a); // sign extends
		sb = int'(b);
		ua = a;
		ub = b;
		if (op == cpu_pkg::mult) begin
			return sa * sb;
		end
		return ua * ub;
	endfunction

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, want);
		end
	endtask

	// read back both registers one cycle apart
	task automatic check_hilo();
		@(posedge aclk);
		rd_sel <= cpu_pkg::hi;
		@(negedge aclk);
		check_eq("hi", hilo_rdata, exp_hi);
		@(posedge aclk);
		rd_sel <= cpu_pkg::lo;
		@(negedge aclk);
		check_eq("lo", hilo_rdata, exp_lo);
	endtask

	task automatic run_mul(input cpu_pkg::md_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] p;
		p = mul_ref(op, a, b);
		@(posedge aclk);
		md_req <= '{op: op, a: a, b: b};
		start  <= 1'b1;
		@(negedge aclk);
		check_eq("busy on mult", busy, 1'b0);
		@(posedge aclk);
		start  <= 1'b0;
		rd_sel <= cpu_pkg::hi;
		@(negedge aclk);
		check_eq("product hi after one edge", hilo_rdata, p[63:32]);
		check_eq("busy after mult", busy, 1'b0);
		exp_hi = p[63:32];
		exp_lo = p[31:0];
		check_hilo();
	endtask

	task automatic run_div(input cpu_pkg::md_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] q;
		logic [31:0] r;
		int          sa;
		int          sb;
		int          edges;
		sa = a;
		sb = b;
		if (op == cpu_pkg::div) begin
			q = sa / sb; // truncates toward zero
			r = sa % sb; // sign of dividend
		end else begin
			q = a / b;
			r = a % b;
		end
		@(posedge aclk);
		md_req <= '{op: op, a: a, b: b};
		start  <= 1'b1;
		rd_sel <= cpu_pkg::lo;
		@(negedge aclk);
		check_eq("busy in div start cycle", busy, 1'b1);
		edges = 0;
		while (busy && edges < cpu_pkg::div_steps + 8) begin
			@(posedge aclk);
			edges++; // start edge counts as 1
			if (edges == 4) begin
				// mult and mtlo while busy must both be dropped
				md_req  <= '{op: cpu_pkg::mult, a: ~a, b: b};
				start   <= 1'b1;
				hilo_wr <= '{en: 1'b1, sel: cpu_pkg::lo, data: ~exp_lo};
			end else begin
				start      <= 1'b0;
				hilo_wr.en <= 1'b0;
			end
			@(negedge aclk);
			check_eq("lo held during divide", hilo_rdata, exp_lo);
		end
		check_eq("edges until busy drops", edges, cpu_pkg::div_steps + 2);
		@(posedge aclk); // div_steps + 2 edges after the start edge
		@(negedge aclk);
		check_eq("quotient in lo", hilo_rdata, q);
		exp_lo = q;
		exp_hi = r;
		check_hilo();
	endtask

	task automatic flushed_start(input cpu_pkg::md_op_e op);
		@(posedge aclk);
		md_req <= '{op: op, a: next_rand(), b: 32'h0000_0135};
		start  <= 1'b1;
		flush  <= 1'b1;
		@(negedge aclk);
		check_eq("busy with flush", busy, 1'b0);
		@(posedge aclk);
		start <= 1'b0;
		flush <= 1'b0;
		@(negedge aclk);
		check_eq("busy after flush", busy, 1'b0);
		check_hilo();
	endtask

	task automatic write_hilo(input cpu_pkg::hilo_sel_e sel, input logic [31:0] data);
		@(posedge aclk);
		hilo_wr <= '{en: 1'b1, sel: sel, data: data};
		rd_sel  <= sel;
		@(posedge aclk);
		hilo_wr.en <= 1'b0;
		@(negedge aclk);
		check_eq("direct write readback", hilo_rdata, data);
		if (sel == cpu_pkg::hi) begin
			exp_hi = data;
		end else begin
			exp_lo = data;
		end
		check_hilo(); // other register untouched
	endtask

	task automatic store(input cpu_pkg::mem_size_e size, input logic [1:0] off,
		input logic [5:0] idx, input logic [31:0] data);
		logic [3:0]  wen;
		logic [31:0] wdata;
		int          i;
		for (i = 0; i < 4; i++) begin
			wen[i] = (size == cpu_pkg::sz_word) || (size == cpu_pkg::sz_half && i / 2 == off[1])
				|| (size == cpu_pkg::sz_byte && i == off);
		end
		case (size)
			cpu_pkg::sz_byte: wdata = {4{data[7:0]}};
			cpu_pkg::sz_half: wdata = {2{data[15:0]}};
			default:          wdata = data;
		endcase
		@(posedge aclk);
		mem_req <= '{wr: 1'b1, rd: 1'b0, size: size, sext: 1'b0,
			addr: cpu_pkg::dsram_base + {24'b0, idx, off}, wdata: data};
		@(negedge aclk);
		check_eq("store lane enables", {28'b0, sram.wen}, {28'b0, wen});
		check_eq("store address", sram.addr, {24'b0, idx, 2'b00});
		check_eq("store data", sram.wdata, wdata);
		for (i = 0; i < 4; i++) begin
			if (wen[i]) begin
				ref_mem[idx][8*i +: 8] = wdata[8*i +: 8];
			end
		end
		@(posedge aclk);
		mem_req.wr <= 1'b0;
		@(negedge aclk);
		check_eq("sram word after store", mem[idx], ref_mem[idx]);
	endtask

	task automatic load(input cpu_pkg::mem_size_e size, input logic sext, input logic [1:0] off,
		input logic [5:0] idx);
		logic [31:0] word;
		logic [31:0] want;
		word = ref_mem[idx] >> (8 * off); // field moved to bit 0
		case (size)
			cpu_pkg::sz_byte: begin
				want = {24'b0, word[7:0]};
				if (sext && word[7]) begin
					want[31:8] = '1;
				end
			end
			cpu_pkg::sz_half: begin
				want = {16'b0, word[15:0]};
				if (sext && word[15]) begin
					want[31:16] = '1;
				end
			end
			default: want = ref_mem[idx];
		endcase
		@(posedge aclk);
		mem_req <= '{wr: 1'b0, rd: 1'b1, size: size, sext: sext,
			addr: cpu_pkg::dsram_base + {24'b0, idx, off}, wdata: 32'h0};
		@(posedge aclk);
		// request shape changes in the data cycle
		mem_req.rd        <= 1'b0;
		mem_req.sext      <= ~sext;
		mem_req.size      <= (size == cpu_pkg::sz_word) ? cpu_pkg::sz_byte : cpu_pkg::sz_word;
		mem_req.addr[1:0] <= ~off;
		@(negedge aclk);
		check_eq("load data", load_data, want);
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s;
		int          i;
		int          r;
		int          off;
		aresetn    <= 1'b0;
		md_req     <= '0;
		start      <= 1'b0;
		flush      <= 1'b0;
		hilo_wr    <= '0;
		rd_sel     <= cpu_pkg::lo;
		mem_req    <= '0;
		sram_rdata <= '0;
		for (i = 0; i < 64; i++) begin
			mem[i]     <= 32'h5a3c_0f96 ^ (i * 32'h9e37_79b9); // whole index feeds in
			ref_mem[i]  = 32'h5a3c_0f96 ^ (i * 32'h9e37_79b9);
		end
		repeat (8) @(posedge aclk);
		aresetn <= 1'b1;
		@(negedge aclk);
		check_eq("busy after reset", busy, 1'b0);
		check_hilo();
		for (i = 0; i < n_mul; i++) begin
			run_mul((i % 2 == 0) ? cpu_pkg::mult : cpu_pkg::multu, next_rand(), next_rand());
		end
		for (i = 0; i < n_div; i++) begin
			a = next_rand();
			s = next_rand();
			b = s >> a[4:0]; // spread divisor sizes
			if (s[0]) begin
				b = -b;
			end
			if (b == 0) begin
				b = 32'd7;
			end
			if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
				b = 32'd3; // overflow case
			end
			run_div((i % 2 == 0) ? cpu_pkg::div : cpu_pkg::divu, a, b);
		end
		flushed_start(cpu_pkg::mult);
		flushed_start(cpu_pkg::div);
		write_hilo(cpu_pkg::hi, next_rand());
		write_hilo(cpu_pkg::lo, next_rand());
		write_hilo(cpu_pkg::lo, next_rand());
		write_hilo(cpu_pkg::hi, next_rand());
		for (r = 0; r < 2; r++) begin
			s = next_rand();
			for (off = 0; off < 4; off++) begin
				store(cpu_pkg::sz_byte, off[1:0], s[7:2], next_rand());
				load(cpu_pkg::sz_byte, 1'b0, off[1:0], s[7:2]);
				load(cpu_pkg::sz_byte, 1'b1, off[1:0], s[13:8]);
			end
			for (off = 0; off < 4; off += 2) begin
				store(cpu_pkg::sz_half, off[1:0], s[19:14], next_rand());
				load(cpu_pkg::sz_half, 1'b0, off[1:0], s[19:14]);
				load(cpu_pkg::sz_half, 1'b1, off[1:0], s[25:20]);
			end
			store(cpu_pkg::sz_word, 2'b00, s[31:26], next_rand());
			load(cpu_pkg::sz_word, 1'b0, 2'b00, s[31:26]);
		end
		repeat (2) @(posedge aclk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// watchdog sized from the op count
	initial begin
		repeat (n_ops * (cpu_pkg::div_steps + 6) + 200) @(posedge aclk);
		$display("watchdog expired before all tests finished, errors so far: %0d", errors);
		$display("test failed");
		$finish;
	end

endmodule

// ==== sources.f ====
logic/cpu_pkg.sv
logic/hilo_ctrl.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/hilo_reg.sv
logic/dsram_bridge.sv
logic/exu_top.sv
verif/exu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = exu_tb
FILELIST  = sources.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
